// File: hdl/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // address split
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS         = 8;
    localparam int VPN_LEVEL_BITS   = 4;   // vpn1 and vpn0
    localparam int PPN_BITS         = 8;
    localparam int ASID_BITS        = 4;
    localparam int VADDR_BITS       = VPN_BITS + PAGE_OFFSET_BITS;
    localparam int PADDR_BITS       = PPN_BITS + PAGE_OFFSET_BITS;

    // tlb geometry, direct mapped
    localparam int TLB_ENTRIES    = 8;
    localparam int TLB_INDEX_BITS = $clog2(TLB_ENTRIES);
    localparam int TLB_TAG_BITS   = VPN_BITS - TLB_INDEX_BITS;

    // page table ram, 16-word tables back to back
    localparam int PT_WORDS     = 256;
    localparam int PT_ADDR_BITS = $clog2(PT_WORDS);

    // pte layout: {ppn, D, A, G, U, X, W, R, V}
    localparam int PTE_PERM_BITS = 8;
    localparam int PTE_BITS      = PPN_BITS + PTE_PERM_BITS;
    localparam int PTE_PPN_LSB   = PTE_PERM_BITS;
    localparam int PTE_V         = 0;
    localparam int PTE_R         = 1;
    localparam int PTE_W         = 2;
    localparam int PTE_X         = 3;
    localparam int PTE_U         = 4;
    // G, A and D sit at bits 5..7 and are carried but never interpreted

    typedef logic [VADDR_BITS-1:0]     vaddr_t;
    typedef logic [PADDR_BITS-1:0]     paddr_t;
    typedef logic [VPN_BITS-1:0]       vpn_t;
    typedef logic [PPN_BITS-1:0]       ppn_t;
    typedef logic [ASID_BITS-1:0]      asid_t;
    typedef logic [PT_ADDR_BITS-1:0]   pt_addr_t;
    typedef logic [PTE_BITS-1:0]       pte_t;
    typedef logic [TLB_INDEX_BITS-1:0] tlb_idx_t;
    typedef logic [TLB_TAG_BITS-1:0]   tlb_tag_t;

    typedef enum logic [1:0] {
        FLUSH,      // clearing entries, also the reset state
        READY,
        WALK,       // waiting on the page walker
        RESPOND
    } tlb_state_t;

    typedef enum logic [1:0] {
        IDLE,
        LEVEL1,
        LEVEL0,
        DONE
    } walk_state_t;

endpackage

`default_nettype wire

// File: hdl/walk_if.sv
`timescale 1ns/1ps
`default_nettype none

// one page walk: level request from a tlb, done pulse back from the walker
interface walk_if
    import mmu_pkg::*;
();

    logic                      req;     // held until done
    vpn_t                      vpn;
    logic [VPN_LEVEL_BITS-1:0] root;    // root table number
    pte_t                      pte;
    logic                      fault;
    logic                      done;    // single cycle

    modport requester (
        output req, vpn, root,
        input  pte, fault, done
    );

    modport walker (
        input  req, vpn, root,
        output pte, fault, done
    );

endinterface

`default_nettype wire

// File: hdl/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb
    import mmu_pkg::*;
#(
    parameter bit FETCH_PORT = 1'b1     // 1 = instruction side, 0 = data side
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      req,
    input  vaddr_t                    vaddr,
    input  logic                      write,
    input  logic                      satp_mode,
    input  asid_t                     satp_asid,
    input  logic [VPN_LEVEL_BITS-1:0] satp_root,
    input  logic                      user_mode,
    input  logic                      flush,
    output logic                      done,
    output paddr_t                    paddr,
    output logic                      fault,
    output logic                      flush_done,
    walk_if.requester                 walk
);

    tlb_state_t state;
    tlb_idx_t   flush_idx;

    // entry storage
    logic       valid_arr [TLB_ENTRIES];
    asid_t      asid_arr  [TLB_ENTRIES];
    tlb_tag_t   tag_arr   [TLB_ENTRIES];
    pte_t       pte_arr   [TLB_ENTRIES];

    // request captured in READY
    vaddr_t     req_vaddr;
    logic       req_write;

    vpn_t       in_vpn;
    tlb_idx_t   in_idx;
    tlb_tag_t   in_tag;
    vpn_t       req_vpn;
    logic       hit;
    pte_t       hit_pte;
    logic       accept;
    paddr_t     lookup_paddr;
    logic       lookup_fault;
    paddr_t     walk_paddr;
    logic       walk_fault;
    logic       fill;

    // access rights for this port against a leaf pte
    function automatic logic perm_fault(input pte_t pte, input logic is_write,
                                        input logic umode);
        logic denied;
        if (FETCH_PORT)
            denied = !pte[PTE_X];
        else if (is_write)
            denied = !pte[PTE_W];
        else
            denied = !pte[PTE_R];
        if (umode && !pte[PTE_U])
            denied = 1'b1;      // supervisor-only page
        return denied;
    endfunction

    assign in_vpn  = vaddr[PAGE_OFFSET_BITS +: VPN_BITS];
    assign in_idx  = in_vpn[TLB_INDEX_BITS-1:0];
    assign in_tag  = in_vpn[VPN_BITS-1:TLB_INDEX_BITS];
    assign req_vpn = req_vaddr[PAGE_OFFSET_BITS +: VPN_BITS];

    assign hit_pte = pte_arr[in_idx];
    assign hit     = valid_arr[in_idx] && (tag_arr[in_idx] == in_tag)
                     && (asid_arr[in_idx] == satp_asid);

    // new request taken this cycle, flush wins over it
    assign accept = (state == READY) && req && !flush;

    always_comb begin
        if (!satp_mode) begin
            lookup_paddr = paddr_t'(vaddr);     // translation off
            lookup_fault = 1'b0;
        end else begin
            lookup_paddr = {hit_pte[PTE_PPN_LSB +: PPN_BITS], vaddr[PAGE_OFFSET_BITS-1:0]};
            lookup_fault = perm_fault(hit_pte, write, user_mode);
        end
    end

    assign walk_paddr = {walk.pte[PTE_PPN_LSB +: PPN_BITS], req_vaddr[PAGE_OFFSET_BITS-1:0]};
    assign walk_fault = walk.fault || perm_fault(walk.pte, req_write, user_mode);
    assign fill       = (state == WALK) && walk.done && !walk.fault;

    assign walk.req  = (state == WALK);
    assign walk.vpn  = req_vpn;
    assign walk.root = satp_root;

    assign flush_done = (state == FLUSH) && (flush_idx == tlb_idx_t'(TLB_ENTRIES - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= FLUSH;
            flush_idx <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                FLUSH: begin
                    flush_idx <= flush_idx + 1'b1;  // wraps back to 0
                    if (flush_done)
                        state <= READY;
                end
                READY: begin
                    if (flush) begin
                        state <= FLUSH;
                    end else if (req) begin
                        if (!satp_mode || hit) begin
                            done  <= 1'b1;
                            state <= RESPOND;
                        end else begin
                            state <= WALK;
                        end
                    end
                end
                WALK: begin
                    if (walk.done) begin
                        done  <= 1'b1;
                        state <= RESPOND;
                    end
                end
                RESPOND: state <= READY;   // requester drops req now
                default: state <= FLUSH;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_vaddr <= vaddr;
            req_write <= write;
            paddr     <= lookup_paddr;  // junk on a miss, replaced after the walk
            fault     <= lookup_fault;
        end
        if ((state == WALK) && walk.done) begin
            paddr <= walk_paddr;
            fault <= walk_fault;
        end
    end

    // entries, only successful walks are cached
    always_ff @(posedge CLK) begin
        if (state == FLUSH) begin
            valid_arr[flush_idx] <= 1'b0;
        end else if (fill) begin
            valid_arr[req_vpn[TLB_INDEX_BITS-1:0]] <= 1'b1;
            asid_arr[req_vpn[TLB_INDEX_BITS-1:0]]  <= satp_asid;
            tag_arr[req_vpn[TLB_INDEX_BITS-1:0]]   <= req_vpn[VPN_BITS-1:TLB_INDEX_BITS];
            pte_arr[req_vpn[TLB_INDEX_BITS-1:0]]   <= walk.pte;
        end
    end

endmodule

`default_nettype wire

// File: hdl/walk_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module walk_arbiter
    import mmu_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    walk_if.walker    port_i,
    walk_if.walker    port_d,
    walk_if.requester walker
);

    logic grant_valid;  // a walk is in flight
    logic grant_d;      // owner of that walk, 1 = data side
    logic last_d;       // side served last
    logic pick_d;
    logic sel_d;

    // round robin when both ask, otherwise whoever asks
    always_comb begin
        if (port_i.req && port_d.req)
            pick_d = !last_d;
        else
            pick_d = port_d.req;
    end

    assign sel_d = grant_valid ? grant_d : pick_d;

    // forward request without a register stage
    assign walker.req  = sel_d ? port_d.req : port_i.req;
    assign walker.vpn  = sel_d ? port_d.vpn : port_i.vpn;
    assign walker.root = sel_d ? port_d.root : port_i.root;

    // response goes to the owner only
    assign port_i.done  = walker.done && !sel_d;
    assign port_i.fault = walker.fault && !sel_d;
    assign port_i.pte   = sel_d ? pte_t'(0) : walker.pte;
    assign port_d.done  = walker.done && sel_d;
    assign port_d.fault = walker.fault && sel_d;
    assign port_d.pte   = sel_d ? walker.pte : pte_t'(0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            grant_valid <= 1'b0;
            grant_d     <= 1'b0;
            last_d      <= 1'b1;    // instruction side first
        end else begin
            if (!grant_valid && walker.req) begin
                grant_valid <= 1'b1;
                grant_d     <= pick_d;
            end
            if (walker.done) begin
                grant_valid <= 1'b0;
                last_d      <= grant_d;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/page_walker.sv
`timescale 1ns/1ps
`default_nettype none

module page_walker
    import mmu_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    walk_if.walker   walk,
    input  logic     pt_we,
    input  pt_addr_t pt_addr,
    input  pte_t     pt_wdata
);

    walk_state_t state;

    pte_t pt_mem [PT_WORDS];    // all page tables

    logic [VPN_LEVEL_BITS-1:0] vpn1;
    logic [VPN_LEVEL_BITS-1:0] vpn0;
    logic [VPN_LEVEL_BITS-1:0] next_tbl;    // level 0 table from the pointer
    pt_addr_t                  rd_addr;
    pte_t                      rd_pte;
    logic                      rd_pointer;
    pte_t                      pte_q;
    logic                      fault_q;

    assign vpn1 = walk.vpn[VPN_BITS-1 -: VPN_LEVEL_BITS];
    assign vpn0 = walk.vpn[VPN_LEVEL_BITS-1:0];

    // table k starts at word k*16, so the word index is just {table, vpn field}
    assign rd_addr = (state == LEVEL0) ? {next_tbl, vpn0} : {walk.root, vpn1};
    assign rd_pte  = pt_mem[rd_addr];

    // V set with R, W and X clear points to the next level
    assign rd_pointer = rd_pte[PTE_V] && !(rd_pte[PTE_R] || rd_pte[PTE_W] || rd_pte[PTE_X]);

    assign walk.done  = (state == DONE);
    assign walk.pte   = pte_q;
    assign walk.fault = fault_q;

    // load port
    always_ff @(posedge CLK) begin
        if (pt_we)
            pt_mem[pt_addr] <= pt_wdata;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (walk.req)
                        state <= LEVEL1;
                end
                LEVEL1: begin
                    if (rd_pointer)
                        state <= LEVEL0;
                    else
                        state <= DONE;  // invalid or superpage leaf
                end
                LEVEL0:  state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // walk result
    always_ff @(posedge CLK) begin
        case (state)
            LEVEL1: begin
                next_tbl <= rd_pte[PTE_PPN_LSB +: VPN_LEVEL_BITS];
                pte_q    <= rd_pte;
                fault_q  <= !rd_pointer;    // no leaf allowed at level 1
            end
            LEVEL0: begin
                pte_q   <= rd_pte;
                fault_q <= !rd_pte[PTE_V] || rd_pointer;
            end
            default: begin
                pte_q   <= pte_q;
                fault_q <= fault_q;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    // instruction port
    input  logic                      i_req,
    input  vaddr_t                    i_vaddr,
    output logic                      i_done,
    output paddr_t                    i_paddr,
    output logic                      i_fault,
    // data port
    input  logic                      d_req,
    input  vaddr_t                    d_vaddr,
    input  logic                      d_write,
    output logic                      d_done,
    output paddr_t                    d_paddr,
    output logic                      d_fault,
    // shared control
    input  logic                      satp_mode,
    input  asid_t                     satp_asid,
    input  logic [VPN_LEVEL_BITS-1:0] satp_root,
    input  logic                      user_mode,
    input  logic                      flush,
    output logic                      flush_done,
    // page table load
    input  logic                      pt_we,
    input  pt_addr_t                  pt_addr,
    input  pte_t                      pt_wdata
);

    logic itlb_flush_done;
    logic dtlb_flush_done;

    walk_if itlb_walk ();
    walk_if dtlb_walk ();
    walk_if pw_walk ();

    tlb #(.FETCH_PORT(1'b1)) itlb (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (i_req),
        .vaddr      (i_vaddr),
        .write      (1'b0),     // fetches never write
        .satp_mode  (satp_mode),
        .satp_asid  (satp_asid),
        .satp_root  (satp_root),
        .user_mode  (user_mode),
        .flush      (flush),
        .done       (i_done),
        .paddr      (i_paddr),
        .fault      (i_fault),
        .flush_done (itlb_flush_done),
        .walk       (itlb_walk.requester)
    );

    tlb #(.FETCH_PORT(1'b0)) dtlb (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (d_req),
        .vaddr      (d_vaddr),
        .write      (d_write),
        .satp_mode  (satp_mode),
        .satp_asid  (satp_asid),
        .satp_root  (satp_root),
        .user_mode  (user_mode),
        .flush      (flush),
        .done       (d_done),
        .paddr      (d_paddr),
        .fault      (d_fault),
        .flush_done (dtlb_flush_done),
        .walk       (dtlb_walk.requester)
    );

    walk_arbiter arbiter (
        .CLK    (CLK),
        .nRST   (nRST),
        .port_i (itlb_walk.walker),
        .port_d (dtlb_walk.walker),
        .walker (pw_walk.requester)
    );

    page_walker walker (
        .CLK      (CLK),
        .nRST     (nRST),
        .walk     (pw_walk.walker),
        .pt_we    (pt_we),
        .pt_addr  (pt_addr),
        .pt_wdata (pt_wdata)
    );

    // both flushes start together so the pulses line up
    assign flush_done = itlb_flush_done & dtlb_flush_done;

endmodule

`default_nettype wire

// File: verification/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb
    import mmu_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_ROW = 40;

    // pte permission bits
    localparam logic [7:0] P_V = 8'h01;
    localparam logic [7:0] P_R = 8'h02;
    localparam logic [7:0] P_U = 8'h10;
    localparam logic [7:0] RWX = 8'h0f;     // includes V

    typedef enum {OP_LOAD, OP_SATP, OP_FETCH, OP_READ, OP_WRITE, OP_BOTH, OP_FLUSH} op_t;

    typedef struct {
        string name;
        op_t   op;
        vpn_t  vpn_i;       // fetch page, or word index for a load
        vpn_t  vpn_d;       // data page
        pte_t  data;        // pte to load, or packed satp fields
        logic  fault_i;
        logic  fault_d;
    } step_t;

    logic CLK = 1'b0;
    logic nRST;
    logic i_req, d_req, d_write;
    vaddr_t i_vaddr, d_vaddr;
    logic i_done, i_fault, d_done, d_fault;
    paddr_t i_paddr, d_paddr;
    logic satp_mode, user_mode, flush, flush_done;
    asid_t satp_asid;
    logic [VPN_LEVEL_BITS-1:0] satp_root;
    logic pt_we;
    pt_addr_t pt_addr;
    pte_t pt_wdata;

    step_t steps [$];
    pte_t  pt_model [PT_WORDS];     // mirror of the page-table ram
    logic  model_mode;
    logic  model_user;
    asid_t model_asid;
    logic [3:0] model_root;
    int    cycle_count = 0;
    int    cycle_limit;

    // direct-mapped tlb contents, port 0 = instruction, 1 = data
    logic  tlb_valid [2][TLB_ENTRIES];
    asid_t tlb_asid  [2][TLB_ENTRIES];
    vpn_t  tlb_vpn   [2][TLB_ENTRIES];

    mmu_top mmu_top_inst (.*);

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_paddr(input string name, input paddr_t expected, input paddr_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected paddr %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_fault(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected fault %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // a hit answers one cycle after the request is sampled
    task automatic check_hit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected hit %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // the table's fault column and the page-table mirror must tell the same story
    task automatic confirm_table(input string name, input logic model, input logic listed);
        if (model !== listed) begin
            $display("step %s: table lists fault %b but the page-table model gives %b",
                     name, listed, model);
            abort_run();
        end
    endtask

    function automatic pte_t pointer_pte(input logic [3:0] tbl);
        return {4'h0, tbl, P_V};
    endfunction

    function automatic pte_t leaf_pte(input ppn_t ppn, input logic [7:0] perms);
        return {ppn, perms};
    endfunction

    // {mode, user, 6'b0, asid, root}
    function automatic pte_t satp_fields(input logic mode, input asid_t asid,
                                         input logic [3:0] root, input logic user);
        return {mode, user, 6'b000000, asid, root};
    endfunction

    task automatic append_step(input string name, input op_t op, input vpn_t vpn_i,
                               input vpn_t vpn_d, input pte_t data,
                               input logic fault_i, input logic fault_d);
        step_t s;
        s.name    = name;
        s.op      = op;
        s.vpn_i   = vpn_i;
        s.vpn_d   = vpn_d;
        s.data    = data;
        s.fault_i = fault_i;
        s.fault_d = fault_d;
        steps.push_back(s);
    endtask

    task automatic clear_tlb_model();
        for (int p = 0; p < 2; p++)
            for (int e = 0; e < TLB_ENTRIES; e++)
                tlb_valid[p][e] = 1'b0;
    endtask

    function automatic logic expect_hit(input int port, input vpn_t vpn);
        int e;
        e = vpn % TLB_ENTRIES;
        if (!model_mode)
            return 1'b1;    // pass-through answers like a hit
        return tlb_valid[port][e] && (tlb_vpn[port][e] == vpn)
               && (tlb_asid[port][e] == model_asid);
    endfunction

    task automatic fill_tlb_model(input int port, input vpn_t vpn);
        int e;
        e = vpn % TLB_ENTRIES;
        tlb_valid[port][e] = 1'b1;
        tlb_asid[port][e]  = model_asid;
        tlb_vpn[port][e]   = vpn;
    endtask

    // expected result from the two-level table rules
    task automatic predict(input vaddr_t va, input logic fetch, input logic wr,
                           output paddr_t pa, output logic flt, output logic wflt);
        pte_t l1;
        pte_t l0;
        logic denied;
        l1 = pt_model[{model_root, va[19:16]}];
        l0 = pt_model[{l1[11:8], va[15:12]}];
        pa = {l0[15:8], va[11:0]};
        wflt = 1'b0;
        if (!model_mode) begin
            pa  = va;
            flt = 1'b0;
        end else if (!l1[0] || (l1[3:1] != 3'b000)) begin
            flt  = 1'b1;    // invalid, or superpage leaf
            wflt = 1'b1;
        end else if (!l0[0] || (l0[3:1] == 3'b000)) begin
            flt  = 1'b1;    // invalid, or pointer at level 0
            wflt = 1'b1;
        end else begin
            if (fetch)
                denied = !l0[3];
            else if (wr)
                denied = !l0[2];
            else
                denied = !l0[1];
            flt = denied || (model_user && !l0[4]);
        end
    endtask

    task automatic write_pte(input pt_addr_t addr, input pte_t value);
        @(posedge CLK);
        pt_we    <= 1'b1;
        pt_addr  <= addr;
        pt_wdata <= value;
        pt_model[addr] = value;
    endtask

    // one access on either port or both, each port released after its own done
    task automatic access(input step_t s);
        logic use_i, use_d, got_i, got_d;
        vaddr_t va_i, va_d;
        paddr_t pa_i, pa_d, exp_pa_i, exp_pa_d;
        logic f_i, f_d, exp_f_i, exp_f_d;
        logic wf_i, wf_d, hit_i, hit_d;
        int iter, lat_i, lat_d;
        use_i = (s.op == OP_FETCH) || (s.op == OP_BOTH);
        use_d = (s.op != OP_FETCH);
        va_i  = {s.vpn_i, 12'($urandom)};
        va_d  = {s.vpn_d, 12'($urandom)};
        predict(va_i, 1'b1, 1'b0, exp_pa_i, exp_f_i, wf_i);
        predict(va_d, 1'b0, s.op == OP_WRITE, exp_pa_d, exp_f_d, wf_d);
        hit_i = expect_hit(0, s.vpn_i);
        hit_d = expect_hit(1, s.vpn_d);
        iter  = 0;
        lat_i = 0;
        lat_d = 0;
        @(posedge CLK);
        i_req   <= use_i;
        i_vaddr <= va_i;
        d_req   <= use_d;
        d_vaddr <= va_d;
        d_write <= (s.op == OP_WRITE);
        got_i = !use_i;
        got_d = !use_d;
        while (!(got_i && got_d)) begin
            @(negedge CLK);
            iter = iter + 1;
            if (i_done) begin
                if (got_i) begin
                    $display("step %s: instruction port gave a done it was not owed", s.name);
                    abort_run();
                end
                got_i = 1'b1;
                lat_i = iter;
                pa_i  = i_paddr;
                f_i   = i_fault;
            end
            if (d_done) begin
                if (got_d) begin
                    $display("step %s: data port gave a done it was not owed", s.name);
                    abort_run();
                end
                got_d = 1'b1;
                lat_d = iter;
                pa_d  = d_paddr;
                f_d   = d_fault;
            end
            @(posedge CLK);
            if (got_i)
                i_req <= 1'b0;
            if (got_d)
                d_req <= 1'b0;
        end
        if (use_i) begin
            confirm_table({s.name, "/i"}, exp_f_i, s.fault_i);
            check_hit({s.name, "/i"}, hit_i, lat_i == 2);
            check_fault({s.name, "/i"}, exp_f_i, f_i);
            if (!exp_f_i)
                check_paddr({s.name, "/i"}, exp_pa_i, pa_i);
            if (model_mode && !hit_i && !wf_i)
                fill_tlb_model(0, s.vpn_i);
        end
        if (use_d) begin
            confirm_table({s.name, "/d"}, exp_f_d, s.fault_d);
            check_hit({s.name, "/d"}, hit_d, lat_d == 2);
            check_fault({s.name, "/d"}, exp_f_d, f_d);
            if (!exp_f_d)
                check_paddr({s.name, "/d"}, exp_pa_d, pa_d);
            if (model_mode && !hit_d && !wf_d)
                fill_tlb_model(1, s.vpn_d);
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            OP_LOAD: begin
                write_pte(s.vpn_i, s.data);
                @(posedge CLK);
                pt_we <= 1'b0;
            end
            OP_SATP: begin
                @(posedge CLK);
                satp_mode  <= s.data[15];
                user_mode  <= s.data[14];
                satp_asid  <= s.data[7:4];
                satp_root  <= s.data[3:0];
                model_mode = s.data[15];
                model_user = s.data[14];
                model_asid = s.data[7:4];
                model_root = s.data[3:0];
            end
            OP_FLUSH: begin
                @(posedge CLK);
                flush <= 1'b1;
                @(posedge CLK);
                flush <= 1'b0;
                @(negedge CLK);
                while (!flush_done)
                    @(negedge CLK);
                clear_tlb_model();
            end
            default: access(s);
        endcase
    endtask

    task automatic build_table();
        append_step("satp_off",    OP_SATP,  8'h00, 8'h00,
                    satp_fields(1'b0, 4'h1, 4'h0, 1'b0), 1'b0, 1'b0);
        append_step("off_both",    OP_BOTH,  8'h3a, 8'hc5, '0, 1'b0, 1'b0);
        append_step("off_fetch",   OP_FETCH, 8'hff, 8'h00, '0, 1'b0, 1'b0);
        append_step("ld_root_1",   OP_LOAD,  8'h01, 8'h00, pointer_pte(4'h1), 1'b0, 1'b0);
        append_step("ld_leaf_12",  OP_LOAD,  8'h12, 8'h00, leaf_pte(8'h47, RWX), 1'b0, 1'b0);
        append_step("ld_leaf_13",  OP_LOAD,  8'h13, 8'h00, leaf_pte(8'h48, P_V | P_R), 1'b0, 1'b0);
        append_step("ld_leaf_14",  OP_LOAD,  8'h14, 8'h00, leaf_pte(8'h49, RWX), 1'b0, 1'b0);
        append_step("ld_leaf_15",  OP_LOAD,  8'h15, 8'h00, leaf_pte(8'h4a, RWX | P_U), 1'b0, 1'b0);
        append_step("satp_on",     OP_SATP,  8'h00, 8'h00,
                    satp_fields(1'b1, 4'h1, 4'h0, 1'b0), 1'b0, 1'b0);
        append_step("walk_i",      OP_FETCH, 8'h12, 8'h00, '0, 1'b0, 1'b0);
        append_step("hit_i",       OP_FETCH, 8'h12, 8'h00, '0, 1'b0, 1'b0);
        append_step("walk_d",      OP_READ,  8'h00, 8'h12, '0, 1'b0, 1'b0);
        append_step("hit_d",       OP_WRITE, 8'h00, 8'h12, '0, 1'b0, 1'b0);
        // broken table entries
        append_step("ld_super_02", OP_LOAD,  8'h02, 8'h00, leaf_pte(8'h20, RWX), 1'b0, 1'b0);
        append_step("ld_root_4",   OP_LOAD,  8'h04, 8'h00, pointer_pte(4'h2), 1'b0, 1'b0);
        append_step("ld_ptr_26",   OP_LOAD,  8'h26, 8'h00, pointer_pte(4'h3), 1'b0, 1'b0);
        append_step("flt_invalid", OP_FETCH, 8'h37, 8'h00, '0, 1'b1, 1'b0);
        append_step("flt_l1_leaf", OP_READ,  8'h00, 8'h27, '0, 1'b0, 1'b1);
        append_step("flt_l0_ptr",  OP_FETCH, 8'h46, 8'h00, '0, 1'b1, 1'b0);
        append_step("fix_root_3",  OP_LOAD,  8'h03, 8'h00, pointer_pte(4'h3), 1'b0, 1'b0);
        append_step("fix_leaf_37", OP_LOAD,  8'h37, 8'h00, leaf_pte(8'h5c, RWX), 1'b0, 1'b0);
        append_step("fix_root_2",  OP_LOAD,  8'h02, 8'h00, pointer_pte(4'h3), 1'b0, 1'b0);
        append_step("fix_leaf_26", OP_LOAD,  8'h26, 8'h00, leaf_pte(8'h66, RWX), 1'b0, 1'b0);
        append_step("ok_invalid",  OP_FETCH, 8'h37, 8'h00, '0, 1'b0, 1'b0);
        append_step("ok_l1_leaf",  OP_READ,  8'h00, 8'h27, '0, 1'b0, 1'b0);
        append_step("ok_l0_ptr",   OP_FETCH, 8'h46, 8'h00, '0, 1'b0, 1'b0);
        // permissions
        append_step("perm_no_x",   OP_FETCH, 8'h13, 8'h00, '0, 1'b1, 1'b0);
        append_step("perm_no_w",   OP_WRITE, 8'h00, 8'h13, '0, 1'b0, 1'b1);
        append_step("perm_read",   OP_READ,  8'h00, 8'h13, '0, 1'b0, 1'b0);
        append_step("satp_user",   OP_SATP,  8'h00, 8'h00,
                    satp_fields(1'b1, 4'h1, 4'h0, 1'b1), 1'b0, 1'b0);
        append_step("user_no_u",   OP_FETCH, 8'h14, 8'h00, '0, 1'b1, 1'b0);
        append_step("user_u",      OP_FETCH, 8'h15, 8'h00, '0, 1'b0, 1'b0);
        append_step("satp_super",  OP_SATP,  8'h00, 8'h00,
                    satp_fields(1'b1, 4'h1, 4'h0, 1'b0), 1'b0, 1'b0);
        append_step("super_no_u",  OP_FETCH, 8'h14, 8'h00, '0, 1'b0, 1'b0);
        // both ports miss in the same cycle
        append_step("ld_leaf_18",  OP_LOAD,  8'h18, 8'h00, leaf_pte(8'h71, RWX), 1'b0, 1'b0);
        append_step("ld_leaf_19",  OP_LOAD,  8'h19, 8'h00, leaf_pte(8'h72, RWX), 1'b0, 1'b0);
        append_step("ld_leaf_1a",  OP_LOAD,  8'h1a, 8'h00, leaf_pte(8'h73, RWX), 1'b0, 1'b0);
        append_step("ld_leaf_27",  OP_LOAD,  8'h27, 8'h00, leaf_pte(8'h74, RWX), 1'b0, 1'b0);
        append_step("both_miss",   OP_BOTH,  8'h18, 8'h19, '0, 1'b0, 1'b0);
        append_step("both_miss_2", OP_BOTH,  8'h1a, 8'h47, '0, 1'b0, 1'b0);
        // asid change, then flush over stale entries
        append_step("ld_new_12",   OP_LOAD,  8'h12, 8'h00, leaf_pte(8'h90, RWX), 1'b0, 1'b0);
        append_step("satp_asid_2", OP_SATP,  8'h00, 8'h00,
                    satp_fields(1'b1, 4'h2, 4'h0, 1'b0), 1'b0, 1'b0);
        append_step("asid_fetch",  OP_FETCH, 8'h12, 8'h00, '0, 1'b0, 1'b0);
        append_step("asid_read",   OP_READ,  8'h00, 8'h15, '0, 1'b0, 1'b0);
        append_step("ld_chg_12",   OP_LOAD,  8'h12, 8'h00, leaf_pte(8'h91, RWX), 1'b0, 1'b0);
        append_step("ld_chg_15",   OP_LOAD,  8'h15, 8'h00, leaf_pte(8'h92, RWX | P_U), 1'b0, 1'b0);
        append_step("flush_all",   OP_FLUSH, 8'h00, 8'h00, '0, 1'b0, 1'b0);
        append_step("flush_fetch", OP_FETCH, 8'h12, 8'h00, '0, 1'b0, 1'b0);
        append_step("flush_read",  OP_READ,  8'h00, 8'h15, '0, 1'b0, 1'b0);
    endtask

    initial begin
        nRST      <= 1'b0;
        i_req     <= 1'b0;
        i_vaddr   <= '0;
        d_req     <= 1'b0;
        d_vaddr   <= '0;
        d_write   <= 1'b0;
        satp_mode <= 1'b0;
        satp_asid <= '0;
        satp_root <= '0;
        user_mode <= 1'b0;
        flush     <= 1'b0;
        pt_we     <= 1'b0;
        pt_addr   <= '0;
        pt_wdata  <= '0;
        model_mode = 1'b0;
        model_user = 1'b0;
        model_asid = '0;
        model_root = 4'h0;
        clear_tlb_model();      // reset flush empties both tlbs
        void'($urandom(32'hb7a6));
        build_table();
        cycle_limit = RESET_CYCLES + PT_WORDS + 8 + steps.size() * CYCLES_PER_ROW;

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        // every word starts invalid, ppn field tagged with its own index
        for (int a = 0; a < PT_WORDS; a++)
            write_pte(pt_addr_t'(a), {pt_addr_t'(a), 8'h00});
        @(posedge CLK);
        pt_we <= 1'b0;

        foreach (steps[k])
            apply_step(steps[k]);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: mmu.f
hdl/mmu_pkg.sv
hdl/walk_if.sv
hdl/tlb.sv
hdl/walk_arbiter.sv
hdl/page_walker.sv
hdl/mmu_top.sv
verification/mmu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mmu_tb
FILELIST  = mmu.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
PASS_MSG  = All tests passed!

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
